//--- Bender.yml
package:
  name: fe_front

export_include_dirs:
  - .

sources:
  - files:
      - fe_pkg.sv
      - fb_imem.sv
      - fe_ctl.sv
      - fe_decode.sv
      - fe_top.sv
  - target: test
    files:
      - fe_chk.sv
      - fe_tb.sv

//--- compile.f
+incdir+.
fe_pkg.sv
fb_imem.sv
fe_ctl.sv
fe_decode.sv
fe_top.sv
fe_chk.sv
fe_tb.sv

//--- fb_imem.sv
`timescale 1ns/100ps
`default_nettype none

`include "fe_params.svh"

module fb_imem
    import fe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  t_fe_fb_req             fe_fb_req,
    output t_fb_fe_rsp             fb_fe_rsp,

    input  logic                   load_en,
    input  logic [`FE_IMEM_AW-1:0] load_addr,
    input  t_rv_instr              load_data
);

    localparam int WORDS = 1 << `FE_IMEM_AW;

    logic [31:0]           mem [WORDS];
    logic [`FE_IMEM_AW-1:0] rd_idx;

    logic                  rsp_valid;
    logic [`FE_ADDR_W-1:0] rsp_pc;
    logic [31:0]           rsp_word;

    // Word index, upper address bits wrap
    assign rd_idx = fe_fb_req.addr[`FE_IMEM_AW+1:2];

    // Load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fe_fb_req.valid;
        end
    end

    // Read data and pc follow the request by one cycle
    always_ff @(posedge clk) begin
        if (fe_fb_req.valid) begin
            rsp_pc   <= fe_fb_req.addr;
            rsp_word <= mem[rd_idx];
        end
    end

    always_comb begin
        fb_fe_rsp.valid     = rsp_valid;
        fb_fe_rsp.pc        = rsp_pc;
        fb_fe_rsp.instr.raw = rsp_word;
    end

endmodule

`default_nettype wire

//--- fe_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fe_chk
    import fe_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       stall,
    input logic       valid_fe1,
    input t_instr_pkt instr_fe1,
    input t_fe_fb_req fe_fb_req,
    input t_redirect  redirect,
    input logic       halted
);

    int fails = 0;

    // Stalled output holds unless a redirect flushes it
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && valid_fe1) |=> (redirect.valid || (valid_fe1 && $stable(instr_fe1))))
    else begin
        fails++;
        $error("fetch output changed while stalled");
    end

    // The halt word is the last request
    a_halt_no_req: assert property (@(posedge clk) disable iff (reset)
        (valid_fe1 && instr_fe1.instr.itype.opcode == RV_OP_MISC) |-> !fe_fb_req.valid)
    else begin
        fails++;
        $error("fetch request issued alongside the halt word");
    end

    // Accepted halt word stops fetch in the next cycle
    a_halt_enter: assert property (@(posedge clk) disable iff (reset)
        (valid_fe1 && !stall && instr_fe1.instr.itype.opcode == RV_OP_MISC) |=> halted)
    else begin
        fails++;
        $error("halt not entered after the halt word was accepted");
    end

    // Only reset leaves halt
    a_halt_stay: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
    else begin
        fails++;
        $error("fetch left halt without reset");
    end

endmodule

bind fe_ctl fe_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .valid_fe1 (valid_fe1),
    .instr_fe1 (instr_fe1),
    .fe_fb_req (fe_fb_req),
    .redirect  (redirect),
    .halted    (halted)
);

`default_nettype wire

//--- fe_ctl.sv
`timescale 1ns/100ps
`default_nettype none

`include "fe_params.svh"

module fe_ctl
    import fe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    output t_fe_fb_req fe_fb_req,
    input  t_fb_fe_rsp fb_fe_rsp,

    input  t_redirect  redirect,

    output logic       valid_fe1,
    output t_instr_pkt instr_fe1,
    input  logic       stall,

    output logic       halted
);

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_pdg,
        st_pdg_stall,
        st_drain,
        st_halt
    } t_fe_state;

    t_fe_state  state;
    t_fe_state  state_nxt;

    t_paddr     pc;
    t_instr_pkt capture;
    t_instr_pkt live_pkt;

    logic       rsp_live;
    logic       halt_rsp;
    logic       redirect_take;

    // A response landing in st_req is from the old path and goes unused
    assign rsp_live = fb_fe_rsp.valid;
    assign halt_rsp = rsp_live & (fb_fe_rsp.instr.itype.opcode == RV_OP_MISC);

    // Halt is final, redirects no longer apply
    assign redirect_take = redirect.valid & (state != st_halt);

    always_comb begin
        state_nxt = state;
        unique case (state)
            st_idle:      state_nxt = st_req;
            st_req:       state_nxt = st_pdg;
            st_pdg: begin
                if (halt_rsp) begin
                    state_nxt = stall ? st_drain : st_halt;
                end else if (rsp_live) begin
                    state_nxt = stall ? st_pdg_stall : st_pdg;
                end
            end
            st_pdg_stall: if (!stall) state_nxt = st_pdg;
            st_drain:     if (!stall) state_nxt = st_halt;
            st_halt:      state_nxt = st_halt;
            default:      state_nxt = st_idle;
        endcase
        // Restart from the target, captured word is lost
        if (redirect_take) begin
            state_nxt = st_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Request strobe, one at a time
    always_comb begin
        fe_fb_req.addr  = pc;
        fe_fb_req.valid = (state == st_req)
                        | (state == st_pdg & rsp_live & ~halt_rsp & ~stall)
                        | (state == st_pdg_stall & ~stall);
    end

    // PC points at the next word to request
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FE_RESET_PC;
        end else if (redirect_take) begin
            pc <= redirect.tgt;
        end else if (fe_fb_req.valid) begin
            pc <= pc + 32'd4;
        end
    end

    always_comb begin
        live_pkt.pc    = fb_fe_rsp.pc;
        live_pkt.instr = fb_fe_rsp.instr;
    end

    // Hold a copy for stalled cycles
    always_ff @(posedge clk) begin
        if (state == st_pdg && rsp_live) begin
            capture <= live_pkt;
        end
    end

    // Live word on the first cycle, capture afterwards
    always_comb begin
        instr_fe1 = (state == st_pdg) ? live_pkt : capture;
        valid_fe1 = ~redirect_take
                  & ((state == st_pdg & rsp_live)
                   | (state == st_pdg_stall)
                   | (state == st_drain));
    end

    assign halted = (state == st_halt);

endmodule

`default_nettype wire

//--- fe_decode.sv
`timescale 1ns/100ps
`default_nettype none

module fe_decode
    import fe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       valid_fe1,
    input  t_instr_pkt instr_fe1,
    input  logic       stall,

    output logic       de_valid,
    output t_de_pkt    de_pkt
);

    t_de_pkt   de_nxt;
    t_rv_itype fields;

    assign fields = instr_fe1.instr.itype;

    // Field split on the I-type layout
    always_comb begin
        de_nxt.pc     = instr_fe1.pc;
        de_nxt.opcode = fields.opcode;
        de_nxt.rd     = fields.rd;
        de_nxt.rs1    = fields.rs1;
        de_nxt.funct3 = fields.funct3;
        // imm[11] copied into the upper 20 bits
        de_nxt.imm    = {{20{fields.imm[11]}}, fields.imm};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de_valid <= 1'b0;
        end else if (!stall) begin
            de_valid <= valid_fe1;
        end
    end

    // Payload held while decode is stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            de_pkt <= de_nxt;
        end
    end

endmodule

`default_nettype wire

//--- fe_params.svh
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Byte address width of the fetch path
`define FE_ADDR_W 32

// Instruction memory depth as log2 of words
// 8 gives 256 words, indexed by pc[9:2]
`define FE_IMEM_AW 8

// First fetch address out of reset
`define FE_RESET_PC 32'h0000_0000

`endif

//--- fe_pkg.sv
`default_nettype none

`include "fe_params.svh"

package fe_pkg;

    // One byte address
    typedef logic [`FE_ADDR_W-1:0] t_paddr;

    // I-type field layout of an RV32 instruction word
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_rv_itype;

    // Same word seen raw or split into I-type fields
    typedef union packed {
        logic [31:0] raw;
        t_rv_itype   itype;
    } t_rv_instr;

    // MISC-MEM opcode, used as the halt marker
    localparam logic [6:0] RV_OP_MISC = 7'b0001111;

    // Fetch control to fetch buffer
    typedef struct packed {
        logic   valid;
        t_paddr addr;
    } t_fe_fb_req;

    // Fetch buffer back to fetch control
    typedef struct packed {
        logic      valid;
        t_paddr    pc;
        t_rv_instr instr;
    } t_fb_fe_rsp;

    // Payload handed from fetch to decode
    typedef struct packed {
        t_paddr    pc;
        t_rv_instr instr;
    } t_instr_pkt;

    // Mispredict report from a later stage
    typedef struct packed {
        logic   valid;
        t_paddr tgt;
    } t_redirect;

    // Decode stage output
    typedef struct packed {
        t_paddr      pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [31:0] imm;
    } t_de_pkt;

endpackage

`default_nettype wire

//--- fe_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fe_params.svh"

module fe_tb
    import fe_pkg::*;
;

    localparam int WORDS = 1 << `FE_IMEM_AW;
    // Program lengths of cases 1, 2, 3, 4 and 5
    localparam int CYCLE_LIMIT = (48 + 48 + 121 + 0 + 48) * 4 + 5 * 200;

    logic                   clk;
    logic                   reset;
    logic                   load_en;
    logic [`FE_IMEM_AW-1:0] load_addr;
    t_rv_instr              load_data;
    t_redirect              redirect;
    logic                   stall;
    logic                   de_valid;
    t_de_pkt                de_pkt;
    logic                   halted;

    logic [31:0] prog [WORDS];
    integer      seed = 32'h6373835b;
    int          cycles = 0;
    int          errors = 0;
    int          err_base = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          case_num = 0;

    // Monitor state
    t_paddr      expected_pc;
    logic        halt_seen;
    logic        pend_valid;
    t_paddr      pend_tgt;
    logic        acc_now;
    t_paddr      acc_pc;
    int          acc_cnt;

    fe_top uut (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .redirect  (redirect),
        .stall     (stall),
        .de_valid  (de_valid),
        .de_pkt    (de_pkt),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in case %0d, halt never reached", cycles, case_num);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Expected decode of the word at pc, I-type layout
    function automatic t_de_pkt ref_decode(input t_paddr pc);
        logic [31:0] w;
        t_de_pkt     p;
        w        = prog[pc[`FE_IMEM_AW+1:2]];
        p.pc     = pc;
        p.opcode = w[6:0];
        p.rd     = w[11:7];
        p.funct3 = w[14:12];
        p.rs1    = w[19:15];
        p.imm    = {{20{w[31]}}, w[31:20]};
        return p;
    endfunction

    // Random words, halt opcode only at halt_at
    task automatic make_prog(input int len, input int halt_at);
        logic [31:0] w;
        for (int i = 0; i < len; i++) begin
            w = $random(seed);
            if (w[6:0] == RV_OP_MISC) begin
                w[6:0] = 7'b0010011;
            end
            prog[i] = w;
        end
        prog[halt_at][6:0] = RV_OP_MISC;
    endtask

    task automatic load_prog(input int len);
        reset        = 1'b1;
        stall        = 1'b0;
        redirect     = '0;
        for (int i = 0; i < len; i++) begin
            load_en       = 1'b1;
            load_addr     = i[`FE_IMEM_AW-1:0];
            load_data.raw = prog[i];
            @(posedge clk);
            #1;
        end
        load_en     = 1'b0;
        expected_pc = `FE_RESET_PC;
        halt_seen   = 1'b0;
        pend_valid  = 1'b0;
        acc_cnt     = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_val("de_valid", de_valid, 1'b0);
        check_val("halted", halted, 1'b0);
    endtask

    task automatic wait_accept(input t_paddr pc);
        do begin
            @(posedge clk);
            #1;
        end while (!(acc_now && acc_pc == pc));
    endtask

    task automatic run_to_halt(input logic rand_stall);
        while (!halt_seen) begin
            @(posedge clk);
            #1;
            if (rand_stall) begin
                stall = ($unsigned($random(seed)) % 100) < 30;
            end
        end
        stall = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        check_val("halted", halted, 1'b1);
    endtask

    task automatic start_case(input int num);
        case_num = num;
        err_base = errors;
    endtask

    task automatic report_case(input string name);
        if (errors == err_base) begin
            pass_cnt++;
            $display("Case %0d (%s): pass", case_num, name);
        end else begin
            fail_cnt++;
            $display("Case %0d (%s): fail, %0d mismatches", case_num, name, errors - err_base);
        end
    endtask

    // Compare every accepted decode output with the reference
    always @(posedge clk) begin
        t_de_pkt exp_pkt;
        acc_now = 1'b0;
        if (!reset) begin
            if (de_valid && !stall) begin
                acc_now = 1'b1;
                acc_pc  = expected_pc;
                if (halt_seen) begin
                    errors++;
                    $display("Decode output at %0t arrived after the halt", $time);
                end else begin
                    exp_pkt = ref_decode(expected_pc);
                    check_val("de_pkt", de_pkt, exp_pkt);
                    acc_cnt++;
                    if (exp_pkt.opcode == RV_OP_MISC) begin
                        halt_seen = 1'b1;
                    end
                    expected_pc = expected_pc + 32'd4;
                    if (pend_valid) begin
                        expected_pc = pend_tgt;
                        pend_valid  = 1'b0;
                    end
                end
            end
            // A stalled decode word is still old path and goes out first
            if (redirect.valid && !halt_seen) begin
                if (stall && de_valid) begin
                    pend_valid = 1'b1;
                    pend_tgt   = redirect.tgt;
                end else begin
                    expected_pc = redirect.tgt;
                end
            end
        end
    end

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        redirect  = '0;
        stall     = 1'b0;
        halt_seen = 1'b0;
        acc_now   = 1'b0;

        start_case(1);
        make_prog(48, 47);
        load_prog(48);
        run_to_halt(1'b0);
        check_val("accepted count", acc_cnt, 48);
        report_case("straight line");

        start_case(2);
        load_prog(48);
        run_to_halt(1'b1);
        check_val("accepted count", acc_cnt, 48);
        report_case("random stall");

        start_case(3);
        make_prog(121, 120);
        load_prog(121);
        wait_accept(32'd40);
        redirect.valid = 1'b1;
        redirect.tgt   = 32'd400;
        @(posedge clk);
        #1;
        redirect.valid = 1'b0;
        wait_accept(32'd412);
        // Second redirect lands while decode is stalled
        stall          = 1'b1;
        redirect.valid = 1'b1;
        redirect.tgt   = 32'd432;
        @(posedge clk);
        #1;
        redirect.valid = 1'b0;
        @(posedge clk);
        #1;
        stall = 1'b0;
        run_to_halt(1'b0);
        report_case("redirect");

        start_case(4);
        for (int i = 0; i < 40; i++) begin
            redirect.valid = (i == 30);
            redirect.tgt   = 32'd0;
            @(posedge clk);
            #1;
            check_val("de_valid", de_valid, 1'b0);
            check_val("halted", halted, 1'b1);
        end
        redirect.valid = 1'b0;
        report_case("halt hold");

        start_case(5);
        make_prog(48, 47);
        load_prog(48);
        run_to_halt(1'b0);
        check_val("accepted count", acc_cnt, 48);
        report_case("restart after reset");

        if (uut.u_ctl.u_chk.fails != 0) begin
            $display("Fetch control assertions failed %0d times", uut.u_ctl.u_chk.fails);
        end
        $display("Summary: %0d cases passed, %0d failed, %0d mismatches",
                 pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0 && uut.u_ctl.u_chk.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fe_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fe_params.svh"

module fe_top
    import fe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   load_en,
    input  logic [`FE_IMEM_AW-1:0] load_addr,
    input  t_rv_instr              load_data,

    input  t_redirect              redirect,
    input  logic                   stall,

    output logic                   de_valid,
    output t_de_pkt                de_pkt,
    output logic                   halted
);

    t_fe_fb_req fe_fb_req;
    t_fb_fe_rsp fb_fe_rsp;
    logic       valid_fe1;
    t_instr_pkt instr_fe1;

    fb_imem u_imem (
        .clk       (clk),
        .reset     (reset),
        .fe_fb_req (fe_fb_req),
        .fb_fe_rsp (fb_fe_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    fe_ctl u_ctl (
        .clk       (clk),
        .reset     (reset),
        .fe_fb_req (fe_fb_req),
        .fb_fe_rsp (fb_fe_rsp),
        .redirect  (redirect),
        .valid_fe1 (valid_fe1),
        .instr_fe1 (instr_fe1),
        .stall     (stall),
        .halted    (halted)
    );

    fe_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .valid_fe1 (valid_fe1),
        .instr_fe1 (instr_fe1),
        .stall     (stall),
        .de_valid  (de_valid),
        .de_pkt    (de_pkt)
    );

endmodule

`default_nettype wire
